//--- src/esaxi_pkg.sv
package esaxi_pkg;

   // ####################
   // widths and constants
   // ####################

   localparam int axi_id_w = 12;  // awid/arid/bid/rid
   localparam int addr_w   = 32;
   localparam int data_w   = 32;
   localparam int packet_w = 104; // emesh packet

   localparam logic [addr_w-1:0] return_addr  = 32'h0000_0000; // srcaddr of read requests
   localparam logic [data_w-1:0] timeout_data = 32'hdeadbeef;  // marker word on a dead read

   // ####################
   // encodings
   // ####################

   typedef enum logic [1:0]
   {
      burst_fixed = 2'b00,
      burst_incr  = 2'b01,
      burst_wrap  = 2'b10  // handled like fixed
   } axi_burst_e;

   typedef enum logic [1:0]
   {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } axi_resp_e;

   // access size on the mesh, same code as axi size[1:0]
   typedef enum logic [1:0]
   {
      dm_byte = 2'b00,
      dm_half = 2'b01,
      dm_word = 2'b10
   } emesh_datamode_e;

   typedef enum logic [1:0]
   {
      to_idle    = 2'b00,
      to_armed   = 2'b01,
      to_expired = 2'b10
   } timeout_state_e;

   // captured aw/ar request, 57 bits
   typedef struct packed
   {
      logic [axi_id_w-1:0] id;
      logic [addr_w-1:0]   addr;
      logic [7:0]          len;   // beats minus one
      logic [2:0]          size;
      axi_burst_e          burst;
   } axi_addr_t;

   // emesh packet, write sits in bit 0 and srcaddr on top
   typedef struct packed
   {
      logic [addr_w-1:0] srcaddr;
      logic [data_w-1:0] data;
      logic [addr_w-1:0] dstaddr;
      logic [4:0]        ctrlmode; // always zero here
      emesh_datamode_e   datamode;
      logic              write;
   } emesh_packet_t;

   // write packet, no return address needed
   function automatic emesh_packet_t pack_write(input emesh_datamode_e   datamode,
                                                input logic [addr_w-1:0] dstaddr,
                                                input logic [data_w-1:0] data);
      emesh_packet_t pkt;
      pkt.write    = 1'b1;
      pkt.datamode = datamode;
      pkt.ctrlmode = 5'd0;
      pkt.dstaddr  = dstaddr;
      pkt.data     = data;
      pkt.srcaddr  = '0;
      return pkt;
   endfunction

   // read request, the answer goes back to srcaddr
   function automatic emesh_packet_t pack_read(input emesh_datamode_e   datamode,
                                               input logic [addr_w-1:0] dstaddr,
                                               input logic [addr_w-1:0] srcaddr);
      emesh_packet_t pkt;
      pkt.write    = 1'b0;
      pkt.datamode = datamode;
      pkt.ctrlmode = 5'd0;
      pkt.dstaddr  = dstaddr;
      pkt.data     = '0;
      pkt.srcaddr  = srcaddr;
      return pkt;
   endfunction

   function automatic logic [data_w-1:0] unpack_data(input emesh_packet_t pkt);
      return pkt.data;
   endfunction

endpackage

//--- src/esaxi_read_timeout.sv
`timescale 1ns/100ps

module esaxi_read_timeout
  #(
   parameter int timeout_w = 16
   )
  (
   input  logic s_axi_aclk,
   input  logic s_axi_aresetn,
   input  logic rd_access,   // request left, start counting
   input  logic rr_access,   // answer came back
   output logic expired      // one cycle pulse
   );

   import esaxi_pkg::*;

   timeout_state_e       state;
   logic [timeout_w-1:0] count;
   logic                 count_zero;

   assign count_zero = (count == '0);

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         state <= to_idle;
      else
      begin
         case (state)
            to_idle:    state <= rd_access ? to_armed : to_idle;
            to_armed:
            begin
               if (rr_access)
                  state <= to_idle;
               else if (count_zero)
                  state <= to_expired;   // 2^timeout_w cycles gone
            end
            to_expired: state <= to_idle;
            default:    state <= to_idle;
         endcase
      end
   end

   // preload while idle, count down while armed
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn || state == to_idle)
         count <= '1;
      else if (state == to_armed)
         count <= count - 1'b1;
   end

   assign expired = (state == to_expired);

endmodule

//--- src/esaxi_write.sv
`timescale 1ns/100ps

module esaxi_write
  (
   input  logic                          s_axi_aclk,
   input  logic                          s_axi_aresetn,
   // write address
   input  esaxi_pkg::axi_addr_t          aw,
   input  logic                          awvalid,
   output logic                          awready,
   // write data
   input  logic [esaxi_pkg::data_w-1:0]  wdata,
   input  logic [3:0]                    wstrb,
   input  logic                          wlast,
   input  logic                          wvalid,
   output logic                          wready,
   // write response
   output logic [esaxi_pkg::axi_id_w-1:0] bid,
   output logic [1:0]                    bresp,
   output logic                          bvalid,
   input  logic                          bready,
   // mesh write side
   input  logic                          wr_wait,
   output logic                          wr_access,
   output esaxi_pkg::emesh_packet_t      wr_packet
   );

   import esaxi_pkg::*;

   logic                aw_hs;
   logic                w_hs;
   logic                last_beat;
   logic                write_active;

   logic [axi_id_w-1:0] aw_id_q;     // goes back on bid
   logic [addr_w-1:0]   aw_addr_q;   // current beat address
   logic [2:0]          aw_size_q;
   axi_burst_e          aw_burst_q;

   logic [1:0]          lane;        // lowest strobed byte
   logic [data_w-1:0]   lane_data;

   logic                s1_valid;
   logic [addr_w-1:0]   s1_dstaddr;
   logic [data_w-1:0]   s1_data;
   emesh_datamode_e     s1_mode;
   logic                s2_valid;
   emesh_packet_t       s2_packet;

   assign aw_hs     = awready & awvalid;
   assign w_hs      = wready & wvalid;
   assign last_beat = w_hs & wlast;

   // ####################
   // address channel
   // ####################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         awready      <= 1'b1;
         write_active <= 1'b0;
      end
      else
      begin
         if (aw_hs)
            awready <= 1'b0;
         else if (bvalid && bready)
            awready <= 1'b1;    // reopen once response is gone

         if (aw_hs)
            write_active <= 1'b1;
         else if (last_beat)
            write_active <= 1'b0;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (aw_hs)
      begin
         aw_id_q    <= aw.id;
         aw_addr_q  <= aw.addr;
         aw_size_q  <= aw.size;
         aw_burst_q <= aw.burst;
      end
      else if (w_hs && aw_burst_q == burst_incr)
      begin
         aw_addr_q[addr_w-1:2] <= aw_addr_q[addr_w-1:2] + 1'b1; // next word
         aw_addr_q[1:0]        <= 2'b00;
      end
   end

   // ####################
   // data channel
   // ####################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         wready <= 1'b0;
      else if (last_beat)
         wready <= 1'b0;
      else if (aw_hs || write_active)
         wready <= ~wr_wait;    // back off when mesh is busy
   end

   // first strobed lane picks the byte offset, no strobe maps to lane 3
   always_comb
   begin
      if (wstrb[0])
         lane = 2'd0;
      else if (wstrb[1])
         lane = 2'd1;
      else if (wstrb[2])
         lane = 2'd2;
      else
         lane = 2'd3;
   end

   assign lane_data = wdata >> {lane, 3'b000}; // shift down by lane bytes

   // ####################
   // packet pipeline
   // ####################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s1_valid  <= 1'b0;
         s2_valid  <= 1'b0;
         wr_access <= 1'b0;
      end
      else
      begin
         s1_valid  <= w_hs;
         s2_valid  <= s1_valid;
         wr_access <= s2_valid;  // no stall, mesh soaks up what is in flight
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      s1_dstaddr <= {aw_addr_q[addr_w-1:2], lane};
      s1_data    <= lane_data;
      s1_mode    <= emesh_datamode_e'(aw_size_q[1:0]);
      s2_packet  <= pack_write(s1_mode, s1_dstaddr, s1_data);
      wr_packet  <= s2_packet;
   end

   // ####################
   // response channel
   // ####################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         bvalid <= 1'b0;
      else if (last_beat)
         bvalid <= 1'b1;
      else if (bready)
         bvalid <= 1'b0;
   end

   assign bid   = aw_id_q;
   assign bresp = resp_okay;   // writes never fail

endmodule

//--- src/esaxi_read.sv
`timescale 1ns/100ps

module esaxi_read
  #(
   parameter int timeout_w = 16
   )
  (
   input  logic                           s_axi_aclk,
   input  logic                           s_axi_aresetn,
   // read address
   input  esaxi_pkg::axi_addr_t           ar,
   input  logic                           arvalid,
   output logic                           arready,
   // read data
   output logic [esaxi_pkg::axi_id_w-1:0] rid,
   output logic [esaxi_pkg::data_w-1:0]   rdata,
   output logic [1:0]                     rresp,
   output logic                           rlast,
   output logic                           rvalid,
   input  logic                           rready,
   // mesh read request
   input  logic                           rd_wait,
   output logic                           rd_access,
   output esaxi_pkg::emesh_packet_t       rd_packet,
   // mesh read response
   input  logic                           rr_access,
   input  esaxi_pkg::emesh_packet_t       rr_packet
   );

   import esaxi_pkg::*;

   logic              ar_hs;
   logic              r_hs;
   logic              last_rd_beat;
   logic              read_active;
   logic              ractive_q;   // edge detect for first request
   logic              rnext_q;     // more beats to fetch
   logic              req_held;    // request stalled by rd_wait
   logic              req_due;
   logic              outstanding; // one read in the mesh
   logic              rr_take;
   logic              expired;

   logic [addr_w-1:0] ar_addr_q;
   logic [7:0]        ar_len_q;    // beats left minus one
   logic [2:0]        ar_size_q;
   axi_burst_e        ar_burst_q;

   logic [data_w-1:0] ret_word;

   assign ar_hs        = arready & arvalid;
   assign r_hs         = rvalid & rready;
   assign last_rd_beat = r_hs & rlast;

   // ####################
   // address channel
   // ####################

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         arready     <= 1'b1;
         read_active <= 1'b0;
      end
      else
      begin
         if (ar_hs)
            arready <= 1'b0;
         else if (last_rd_beat)
            arready <= 1'b1;

         if (ar_hs)
            read_active <= 1'b1;
         else if (last_rd_beat)
            read_active <= 1'b0;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rlast <= 1'b0;
      else if (ar_hs)
         rlast <= (ar.len == 8'd0);    // single beat
      else if (r_hs && ar_len_q == 8'd1)
         rlast <= 1'b1;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_hs)
      begin
         rid        <= ar.id;
         ar_addr_q  <= ar.addr;
         ar_len_q   <= ar.len;
         ar_size_q  <= ar.size;
         ar_burst_q <= ar.burst;
      end
      else if (r_hs)
      begin
         ar_len_q <= ar_len_q - 1'b1;
         if (ar_burst_q == burst_incr)
         begin
            ar_addr_q[addr_w-1:2] <= ar_addr_q[addr_w-1:2] + 1'b1;
            ar_addr_q[1:0]        <= 2'b00;
         end
      end
   end

   // ####################
   // request issue
   // ####################

   assign req_due = (read_active & ~ractive_q) | rnext_q | req_held;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         ractive_q   <= 1'b0;
         rnext_q     <= 1'b0;
         req_held    <= 1'b0;
         rd_access   <= 1'b0;
         outstanding <= 1'b0;
      end
      else
      begin
         ractive_q <= read_active;
         rnext_q   <= r_hs & ~rlast;
         rd_access <= req_due & ~rd_wait;
         req_held  <= req_due & rd_wait;   // hold until mesh frees up
         if (rd_access)
            outstanding <= 1'b1;
         else if (rr_take || expired)
            outstanding <= 1'b0;
      end
   end

   always_ff @(posedge s_axi_aclk)
   begin
      rd_packet <= pack_read(emesh_datamode_e'(ar_size_q[1:0]), ar_addr_q, return_addr);
   end

   // ####################
   // response path
   // ####################

   assign rr_take  = rr_access & outstanding;  // stray answers dropped
   assign ret_word = expired ? timeout_data : unpack_data(rr_packet);

   esaxi_read_timeout
     #(
      .timeout_w (timeout_w)
      )
   u_timeout
     (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .rd_access     (rd_access),
      .rr_access     (rr_take),
      .expired       (expired)
      );

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rvalid <= 1'b0;
      else if (rr_take || expired)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (rr_take || expired)
      begin
         rresp <= expired ? resp_slverr : resp_okay;
         case (ar_size_q[1:0])
            2'b00:   rdata <= {4{ret_word[7:0]}};   // byte on every lane
            2'b01:   rdata <= {2{ret_word[15:0]}};
            default: rdata <= ret_word;
         endcase
      end
   end

endmodule

//--- src/esaxi.sv
`timescale 1ns/100ps

module esaxi
  #(
   parameter int timeout_w = 16   // read watchdog width
   )
  (
   input  logic                           s_axi_aclk,
   input  logic                           s_axi_aresetn,
   // write address
   input  logic [esaxi_pkg::axi_id_w-1:0] s_axi_awid,
   input  logic [esaxi_pkg::addr_w-1:0]   s_axi_awaddr,
   input  logic [7:0]                     s_axi_awlen,
   input  logic [2:0]                     s_axi_awsize,
   input  logic [1:0]                     s_axi_awburst,
   input  logic                           s_axi_awvalid,
   output logic                           s_axi_awready,
   // write data
   input  logic [esaxi_pkg::data_w-1:0]   s_axi_wdata,
   input  logic [3:0]                     s_axi_wstrb,
   input  logic                           s_axi_wlast,
   input  logic                           s_axi_wvalid,
   output logic                           s_axi_wready,
   // write response
   output logic [esaxi_pkg::axi_id_w-1:0] s_axi_bid,
   output logic [1:0]                     s_axi_bresp,
   output logic                           s_axi_bvalid,
   input  logic                           s_axi_bready,
   // read address
   input  logic [esaxi_pkg::axi_id_w-1:0] s_axi_arid,
   input  logic [esaxi_pkg::addr_w-1:0]   s_axi_araddr,
   input  logic [7:0]                     s_axi_arlen,
   input  logic [2:0]                     s_axi_arsize,
   input  logic [1:0]                     s_axi_arburst,
   input  logic                           s_axi_arvalid,
   output logic                           s_axi_arready,
   // read data
   output logic [esaxi_pkg::axi_id_w-1:0] s_axi_rid,
   output logic [esaxi_pkg::data_w-1:0]   s_axi_rdata,
   output logic [1:0]                     s_axi_rresp,
   output logic                           s_axi_rlast,
   output logic                           s_axi_rvalid,
   input  logic                           s_axi_rready,
   // mesh side
   output logic                           wr_access,
   output esaxi_pkg::emesh_packet_t       wr_packet,
   input  logic                           wr_wait,
   output logic                           rd_access,
   output esaxi_pkg::emesh_packet_t       rd_packet,
   input  logic                           rd_wait,
   input  logic                           rr_access,
   input  esaxi_pkg::emesh_packet_t       rr_packet
   );

   import esaxi_pkg::*;

   axi_addr_t aw_req;
   axi_addr_t ar_req;

   // flat aw/ar fields into request structs
   assign aw_req = '{id: s_axi_awid, addr: s_axi_awaddr, len: s_axi_awlen,
                     size: s_axi_awsize, burst: axi_burst_e'(s_axi_awburst)};
   assign ar_req = '{id: s_axi_arid, addr: s_axi_araddr, len: s_axi_arlen,
                     size: s_axi_arsize, burst: axi_burst_e'(s_axi_arburst)};

   esaxi_write u_write
     (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .aw            (aw_req),
      .awvalid       (s_axi_awvalid),
      .awready       (s_axi_awready),
      .wdata         (s_axi_wdata),
      .wstrb         (s_axi_wstrb),
      .wlast         (s_axi_wlast),
      .wvalid        (s_axi_wvalid),
      .wready        (s_axi_wready),
      .bid           (s_axi_bid),
      .bresp         (s_axi_bresp),
      .bvalid        (s_axi_bvalid),
      .bready        (s_axi_bready),
      .wr_wait       (wr_wait),
      .wr_access     (wr_access),
      .wr_packet     (wr_packet)
      );

   esaxi_read
     #(
      .timeout_w (timeout_w)
      )
   u_read
     (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .ar            (ar_req),
      .arvalid       (s_axi_arvalid),
      .arready       (s_axi_arready),
      .rid           (s_axi_rid),
      .rdata         (s_axi_rdata),
      .rresp         (s_axi_rresp),
      .rlast         (s_axi_rlast),
      .rvalid        (s_axi_rvalid),
      .rready        (s_axi_rready),
      .rd_wait       (rd_wait),
      .rd_access     (rd_access),
      .rd_packet     (rd_packet),
      .rr_access     (rr_access),
      .rr_packet     (rr_packet)
      );

endmodule

//--- testbench/tb_esaxi.sv
`timescale 1ns/100ps

module tb_esaxi;

   import esaxi_pkg::*;

   // the timeout read is the longest test at about 100 cycles
   localparam int max_cycles = 4000;

   typedef struct packed
   {
      logic [axi_id_w-1:0] id;
      logic [data_w-1:0]   data;
      logic [1:0]          resp;
      logic                last;
   } r_beat_t;

   logic                s_axi_aclk;
   logic                s_axi_aresetn;
   logic [axi_id_w-1:0] s_axi_awid, s_axi_arid, s_axi_bid, s_axi_rid;
   logic [addr_w-1:0]   s_axi_awaddr, s_axi_araddr;
   logic [7:0]          s_axi_awlen, s_axi_arlen;
   logic [2:0]          s_axi_awsize, s_axi_arsize;
   logic [1:0]          s_axi_awburst, s_axi_arburst, s_axi_bresp, s_axi_rresp;
   logic                s_axi_awvalid, s_axi_awready, s_axi_wvalid, s_axi_wready;
   logic [data_w-1:0]   s_axi_wdata, s_axi_rdata;
   logic [3:0]          s_axi_wstrb;
   logic                s_axi_wlast, s_axi_bvalid, s_axi_bready;
   logic                s_axi_arvalid, s_axi_arready;
   logic                s_axi_rlast, s_axi_rvalid, s_axi_rready;
   logic                wr_access, wr_wait, rd_access, rd_wait, rr_access;
   emesh_packet_t       wr_packet, rd_packet, rr_packet;

   integer seed = 32'h1e0d_691f;
   int     cycles = 0;
   int     error_count = 0;
   int     check_count = 0;
   int     test_count = 0;
   int     failed_tests = 0;
   int     test_start_errors = 0;
   bit     responder_on = 1'b1;   // off for the timeout test
   bit     wait_toggle = 1'b0;    // random wr_wait

   emesh_packet_t exp_wr_q[$];    // expected write packets in order
   emesh_packet_t exp_rd_q[$];    // expected read requests
   r_beat_t       exp_r_q[$];     // expected read beats

   logic [data_w-1:0] beat_data[16];
   logic [3:0]        beat_strb[16];

   esaxi #(.timeout_w(6)) u_esaxi
     (
      .s_axi_aclk, .s_axi_aresetn,
      .s_axi_awid, .s_axi_awaddr, .s_axi_awlen, .s_axi_awsize, .s_axi_awburst,
      .s_axi_awvalid, .s_axi_awready,
      .s_axi_wdata, .s_axi_wstrb, .s_axi_wlast, .s_axi_wvalid, .s_axi_wready,
      .s_axi_bid, .s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
      .s_axi_arid, .s_axi_araddr, .s_axi_arlen, .s_axi_arsize, .s_axi_arburst,
      .s_axi_arvalid, .s_axi_arready,
      .s_axi_rid, .s_axi_rdata, .s_axi_rresp, .s_axi_rlast, .s_axi_rvalid, .s_axi_rready,
      .wr_access, .wr_packet, .wr_wait, .rd_access, .rd_packet, .rd_wait,
      .rr_access, .rr_packet
      );

   // ####################
   // clock and watchdog
   // ####################

   initial s_axi_aclk = 1'b0;
   always #5 s_axi_aclk = ~s_axi_aclk;

   always @(posedge s_axi_aclk)
   begin
      cycles = cycles + 1;
      if (cycles >= max_cycles)
      begin
         $display("run stopped: tests did not finish within %0d cycles", max_cycles);
         $display("Result: FAILED");
         $finish;
      end
   end

   // ####################
   // reference model
   // ####################

   function automatic emesh_packet_t expected_write_packet(input logic [31:0] start,
                                                           input int beat,
                                                           input logic [2:0] size,
                                                           input logic [1:0] burst,
                                                           input logic [31:0] data,
                                                           input logic [3:0] strb);
      emesh_packet_t pkt;
      logic [1:0]    lane;
      logic [29:0]   word;
      // lowest strobed byte or lane 3 with no strobe
      lane = strb[0] ? 2'd0 : strb[1] ? 2'd1 : strb[2] ? 2'd2 : 2'd3;
      word = start[31:2];
      if (burst == burst_incr)
         word = word + 30'(beat);   // one word per beat
      pkt.write    = 1'b1;
      pkt.datamode = emesh_datamode_e'(size[1:0]);
      pkt.ctrlmode = 5'd0;
      pkt.dstaddr  = {word, lane};
      pkt.data     = data >> (8 * int'(lane));
      pkt.srcaddr  = 32'd0;
      return pkt;
   endfunction

   // first beat keeps the start address and later incr beats are word aligned
   function automatic logic [31:0] read_addr(input logic [31:0] start, input int beat,
                                             input logic [1:0] burst);
      if (beat == 0 || burst != burst_incr)
         return start;
      return {start[31:2] + 30'(beat), 2'b00};
   endfunction

   function automatic logic [31:0] expected_rdata(input logic [2:0] size,
                                                  input logic [31:0] word);
      case (size[1:0])
         2'b00:   return {4{word[7:0]}};
         2'b01:   return {2{word[15:0]}};
         default: return word;
      endcase
   endfunction

   // what the mesh memory holds at an address
   function automatic logic [31:0] responder_word(input logic [31:0] addr);
      return addr ^ 32'he196_a53c;
   endfunction

   // ####################
   // checks and report
   // ####################

   task automatic check_value(input string name, input logic [packet_w-1:0] got,
                              input logic [packet_w-1:0] exp);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic report_error(input string msg);
      error_count++;
      $display("error at time %0t: %s", $time, msg);
   endtask

   task automatic begin_test();
      test_start_errors = error_count;
   endtask

   task automatic end_test(input string name);
      test_count++;
      if (error_count != test_start_errors)
         failed_tests++;
      $display("test %0d %s done, %0d errors", test_count, name,
               error_count - test_start_errors);
   endtask

   // wr packets and r beats checked mid-cycle where everything is stable
   always @(negedge s_axi_aclk)
   begin : compare_proc
      emesh_packet_t exp_pkt;
      r_beat_t       exp_beat;
      if (s_axi_aresetn && wr_access)
      begin
         if (exp_wr_q.size() == 0)
            report_error("write packet came out with no beat pending");
         else
         begin
            exp_pkt = exp_wr_q.pop_front();
            check_value("wr_packet", wr_packet, exp_pkt);
         end
      end
      if (s_axi_aresetn && s_axi_rvalid && s_axi_rready)
      begin
         if (exp_r_q.size() == 0)
            report_error("read beat returned with none expected");
         else
         begin
            exp_beat = exp_r_q.pop_front();
            check_value("rid", s_axi_rid, exp_beat.id);
            check_value("rdata", s_axi_rdata, exp_beat.data);
            check_value("rresp", s_axi_rresp, exp_beat.resp);
            check_value("rlast", s_axi_rlast, exp_beat.last);
         end
      end
   end

   // ####################
   // mesh side
   // ####################

   always
   begin : responder
      emesh_packet_t req;
      emesh_packet_t exp_req;
      int            delay;
      @(negedge s_axi_aclk);
      if (s_axi_aresetn && rd_access)
      begin
         req = rd_packet;
         if (exp_rd_q.size() == 0)
            report_error("read request sent with none expected");
         else
         begin
            exp_req = exp_rd_q.pop_front();
            check_value("rd_packet", req, exp_req);
         end
         if (responder_on)
         begin
            delay = 1 + int'($unsigned($random(seed)) % 8);   // 1 to 8 cycles
            repeat (delay) @(posedge s_axi_aclk);
            #1;
            rr_packet.write    = 1'b1;
            rr_packet.datamode = req.datamode;
            rr_packet.ctrlmode = 5'd0;
            rr_packet.dstaddr  = req.srcaddr;   // back to the requester
            rr_packet.data     = responder_word(req.dstaddr);
            rr_packet.srcaddr  = 32'd0;
            rr_access          = 1'b1;
            @(posedge s_axi_aclk);
            #1;
            rr_access = 1'b0;
         end
      end
   end

   always @(posedge s_axi_aclk)
   begin
      #1;
      if (wait_toggle)
         wr_wait = ($random(seed) % 2) != 0;
      else
         wr_wait = 1'b0;
   end

   // ####################
   // axi master
   // ####################

   task automatic write_burst(input logic [11:0] id, input logic [31:0] addr, input int beats,
                              input logic [2:0] size, input logic [1:0] burst);
      int i;
      for (i = 0; i < beats; i++)
         exp_wr_q.push_back(expected_write_packet(addr, i, size, burst, beat_data[i],
                                                  beat_strb[i]));
      s_axi_bready  = 1'b1;
      s_axi_awid    = id;
      s_axi_awaddr  = addr;
      s_axi_awlen   = 8'(beats - 1);
      s_axi_awsize  = size;
      s_axi_awburst = burst;
      s_axi_awvalid = 1'b1;
      do @(negedge s_axi_aclk); while (!s_axi_awready);
      @(posedge s_axi_aclk);
      #1;
      s_axi_awvalid = 1'b0;
      for (i = 0; i < beats; i++)
      begin
         s_axi_wdata  = beat_data[i];
         s_axi_wstrb  = beat_strb[i];
         s_axi_wlast  = (i == beats - 1);
         s_axi_wvalid = 1'b1;
         do @(negedge s_axi_aclk); while (!s_axi_wready);   // held off by wr_wait
         @(posedge s_axi_aclk);
         #1;
      end
      s_axi_wvalid = 1'b0;
      s_axi_wlast  = 1'b0;
      do @(negedge s_axi_aclk); while (!s_axi_bvalid);
      check_value("bid", s_axi_bid, id);
      check_value("bresp", s_axi_bresp, resp_okay);
      @(posedge s_axi_aclk);
      #1;
      s_axi_bready = 1'b0;
      while (exp_wr_q.size() != 0)
      begin
         @(posedge s_axi_aclk);   // drain pipeline
         #1;
      end
   endtask

   task automatic read_burst(input logic [11:0] id, input logic [31:0] addr, input int beats,
                             input logic [2:0] size, input logic [1:0] burst,
                             input bit expect_timeout);
      int            i;
      logic [31:0]   beat_addr;
      emesh_packet_t req;
      r_beat_t       beat;
      for (i = 0; i < beats; i++)
      begin
         beat_addr    = read_addr(addr, i, burst);
         req.write    = 1'b0;
         req.datamode = emesh_datamode_e'(size[1:0]);
         req.ctrlmode = 5'd0;
         req.dstaddr  = beat_addr;
         req.data     = 32'd0;
         req.srcaddr  = return_addr;
         exp_rd_q.push_back(req);
         beat.id   = id;
         beat.data = expected_rdata(size, expect_timeout ? timeout_data
                                                         : responder_word(beat_addr));
         beat.resp = expect_timeout ? resp_slverr : resp_okay;
         beat.last = (i == beats - 1);
         exp_r_q.push_back(beat);
      end
      s_axi_rready  = 1'b1;
      s_axi_arid    = id;
      s_axi_araddr  = addr;
      s_axi_arlen   = 8'(beats - 1);
      s_axi_arsize  = size;
      s_axi_arburst = burst;
      s_axi_arvalid = 1'b1;
      do @(negedge s_axi_aclk); while (!s_axi_arready);
      @(posedge s_axi_aclk);
      #1;
      s_axi_arvalid = 1'b0;
      while (exp_r_q.size() != 0)
      begin
         @(posedge s_axi_aclk);   // last handshake lands on this edge
         #1;
      end
      s_axi_rready = 1'b0;
   endtask

   // ####################
   // test sequence
   // ####################

   initial
   begin : main
      int i;
      s_axi_aresetn = 1'b0;
      s_axi_awid    = '0;
      s_axi_awaddr  = '0;
      s_axi_awlen   = '0;
      s_axi_awsize  = '0;
      s_axi_awburst = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata   = '0;
      s_axi_wstrb   = '0;
      s_axi_wlast   = 1'b0;
      s_axi_wvalid  = 1'b0;
      s_axi_bready  = 1'b0;
      s_axi_arid    = '0;
      s_axi_araddr  = '0;
      s_axi_arlen   = '0;
      s_axi_arsize  = '0;
      s_axi_arburst = '0;
      s_axi_arvalid = 1'b0;
      s_axi_rready  = 1'b0;
      wr_wait       = 1'b0;
      rd_wait       = 1'b0;
      rr_access     = 1'b0;
      rr_packet     = '0;
      repeat (5) @(posedge s_axi_aclk);
      #1;
      s_axi_aresetn = 1'b1;

      begin_test();
      beat_data[0] = 32'hcafe_f00d;
      beat_strb[0] = 4'hf;
      write_burst(12'h0a1, 32'h0000_1000, 1, 3'd2, burst_incr);
      end_test("single word write");

      begin_test();
      for (i = 0; i < 4; i++)
      begin
         beat_data[i] = $random(seed);
         beat_strb[i] = 4'b0001 << ($unsigned($random(seed)) % 4);   // one lane each
      end
      write_burst(12'h2b3, 32'h0000_2000, 4, 3'd2, burst_incr);
      for (i = 0; i < 3; i++)
      begin
         beat_data[i] = $random(seed);
         beat_strb[i] = 4'b0001 << ($unsigned($random(seed)) % 4);
      end
      write_burst(12'h2b4, 32'h0000_3040, 3, 3'd0, burst_fixed);
      end_test("incr and fixed write bursts");

      begin_test();
      for (i = 0; i < 8; i++)
      begin
         beat_data[i] = $random(seed);
         beat_strb[i] = 4'hf;
      end
      wait_toggle = 1'b1;
      write_burst(12'h3c5, 32'h0000_4000, 8, 3'd2, burst_incr);
      wait_toggle = 1'b0;
      end_test("write burst under wr_wait");

      begin_test();
      read_burst(12'h4c1, 32'h0000_5003, 3, 3'd0, burst_incr, 1'b0);   // odd start
      read_burst(12'h4c2, 32'h0000_6002, 3, 3'd1, burst_incr, 1'b0);
      read_burst(12'h4c3, 32'h0000_7000, 3, 3'd2, burst_incr, 1'b0);
      end_test("incr read bursts by size");

      begin_test();
      responder_on = 1'b0;
      read_burst(12'h5d1, 32'h0000_8000, 1, 3'd2, burst_incr, 1'b1);
      responder_on = 1'b1;
      read_burst(12'h5d2, 32'h0000_8004, 1, 3'd2, burst_incr, 1'b0);
      end_test("read timeout and recovery");

      if (exp_wr_q.size() != 0 || exp_rd_q.size() != 0 || exp_r_q.size() != 0)
         report_error("expected traffic never showed up");
      $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

//--- all.f
src/esaxi_pkg.sv
src/esaxi_read_timeout.sv
src/esaxi_write.sv
src/esaxi_read.sv
src/esaxi.sv
testbench/tb_esaxi.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_esaxi -f all.f \
		--Mdir obj_dir -o tb_esaxi
	./obj_dir/tb_esaxi | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
